/* source/vga_pkg.sv */
//#######################################
// VGA 640x480 timing constants
// Coordinate and colour types
// Internal pixel stream and output port
//#######################################
`default_nettype none

package vga_pkg;

    // Counter and position width
    typedef logic [9:0] coord_t;

    // 4 bits per channel, red in the top nibble
    typedef logic [11:0] rgb_t;

    // Horizontal timing in pixels
    localparam coord_t H_ACTIVE = 10'd640;
    localparam coord_t H_FRONT  = 10'd16;
    localparam coord_t H_SYNC   = 10'd96;
    localparam coord_t H_TOTAL  = 10'd800;

    // Vertical timing in lines
    localparam coord_t V_ACTIVE = 10'd480;
    localparam coord_t V_FRONT  = 10'd10;
    localparam coord_t V_SYNC   = 10'd2;
    localparam coord_t V_TOTAL  = 10'd525;

    // Sync windows, start inclusive and end exclusive
    localparam coord_t H_SYNC_START = H_ACTIVE + H_FRONT;
    localparam coord_t H_SYNC_END   = H_SYNC_START + H_SYNC;
    localparam coord_t V_SYNC_START = V_ACTIVE + V_FRONT;
    localparam coord_t V_SYNC_END   = V_SYNC_START + V_SYNC;

    // Pixel stream passed between drawing stages
    typedef struct packed {
        coord_t hcount;
        logic   hsync;
        logic   hblnk;
        coord_t vcount;
        logic   vsync;
        logic   vblnk;
        rgb_t   rgb;
    } vga_t;

    // What leaves the chip
    typedef struct packed {
        logic hsync;
        logic vsync;
        rgb_t rgb;
    } vga_port_t;

endpackage

`default_nettype wire

/* source/game_pkg.sv */
//#######################################
// Playfield geometry and start position
// Obstacle rectangle and colour palette
// Button input struct
//#######################################
`default_nettype none

package game_pkg;

    import vga_pkg::*;

    // Visible playfield
    localparam coord_t SCREEN_WIDTH  = 10'd640;
    localparam coord_t SCREEN_HEIGHT = 10'd480;

    // Frame thickness around the playfield
    localparam coord_t BORDER = 10'd8;

    // Half-size of the player square
    localparam coord_t PLAYER_SIZE = 10'd8;

    // Player centre after reset
    localparam coord_t START_X = 10'd32;
    localparam coord_t START_Y = 10'd32;

    // Legal range of the player centre, the square never touches the frame
    localparam coord_t X_MIN = BORDER + PLAYER_SIZE;
    localparam coord_t Y_MIN = BORDER + PLAYER_SIZE;
    localparam coord_t X_MAX = SCREEN_WIDTH - BORDER - PLAYER_SIZE - 10'd1;
    localparam coord_t Y_MAX = SCREEN_HEIGHT - BORDER - PLAYER_SIZE - 10'd1;

    // Obstacle, both corners inclusive
    localparam coord_t OBST_X0 = 10'd100;
    localparam coord_t OBST_X1 = 10'd139;
    localparam coord_t OBST_Y0 = 10'd40;
    localparam coord_t OBST_Y1 = 10'd79;

    // Palette
    localparam rgb_t CYAN         = 12'h0FF;
    localparam rgb_t BORDER_COLOR = 12'hFA0;
    localparam rgb_t OBST_COLOR   = 12'h888;
    localparam rgb_t FLOOR_COLOR  = 12'h131;
    localparam rgb_t BLACK        = 12'h000;

    // Direction buttons, already synchronised to clk
    typedef struct packed {
        logic up;
        logic down;
        logic right;
        logic left;
    } buttons_t;

endpackage

`default_nettype wire

/* source/vga_timing.sv */
//#######################################
// 640x480 VGA timing generator
// Registered counters, sync and blanking
//#######################################
`default_nettype none

module vga_timing
    import vga_pkg::*;
(
    input  logic clk,
    input  logic rst,
    output vga_t vga
);

    coord_t hcount_nxt;
    coord_t vcount_nxt;
    logic   hsync_nxt;
    logic   hblnk_nxt;
    logic   vsync_nxt;
    logic   vblnk_nxt;

    // Next counter values
    always_comb begin
        hcount_nxt = vga.hcount + 10'd1;
        vcount_nxt = vga.vcount;
        if (vga.hcount == H_TOTAL - 10'd1) begin
            hcount_nxt = '0;
            // Line done, step to the next one
            if (vga.vcount == V_TOTAL - 10'd1) begin
                vcount_nxt = '0;
            end else begin
                vcount_nxt = vga.vcount + 10'd1;
            end
        end
    end

    // Sync and blanking decoded from the next counters
    // so they line up with the registered counts
    always_comb begin
        hblnk_nxt = (hcount_nxt >= H_ACTIVE);
        hsync_nxt = (hcount_nxt >= H_SYNC_START) && (hcount_nxt < H_SYNC_END);
        vblnk_nxt = (vcount_nxt >= V_ACTIVE);
        vsync_nxt = (vcount_nxt >= V_SYNC_START) && (vcount_nxt < V_SYNC_END);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vga.hcount <= '0;
            vga.hsync  <= 1'b0;
            vga.hblnk  <= 1'b0;
            vga.vcount <= '0;
            vga.vsync  <= 1'b0;
            vga.vblnk  <= 1'b0;
            vga.rgb    <= '0;
        end else begin
            vga.hcount <= hcount_nxt;
            vga.hsync  <= hsync_nxt;
            vga.hblnk  <= hblnk_nxt;
            vga.vcount <= vcount_nxt;
            vga.vsync  <= vsync_nxt;
            vga.vblnk  <= vblnk_nxt;
            // Colour is filled in by the drawing stages
            vga.rgb    <= '0;
        end
    end

endmodule

`default_nettype wire

/* source/draw_background.sv */
//#######################################
// Background stage
// Frame, obstacle and floor colours
//#######################################
`default_nettype none

module draw_background
    import vga_pkg::*;
    import game_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  vga_t vga_in,
    output vga_t vga_out
);

    rgb_t rgb_nxt;
    logic blank;
    logic on_border;
    logic on_obstacle;

    assign blank = vga_in.hblnk || vga_in.vblnk;

    assign on_border = (vga_in.hcount < BORDER)
                    || (vga_in.hcount >= SCREEN_WIDTH - BORDER)
                    || (vga_in.vcount < BORDER)
                    || (vga_in.vcount >= SCREEN_HEIGHT - BORDER);

    assign on_obstacle = (vga_in.hcount >= OBST_X0) && (vga_in.hcount <= OBST_X1)
                      && (vga_in.vcount >= OBST_Y0) && (vga_in.vcount <= OBST_Y1);

    // Frame wins over the obstacle where they would meet
    always_comb begin
        if (blank) begin
            rgb_nxt = BLACK;
        end else if (on_border) begin
            rgb_nxt = BORDER_COLOR;
        end else if (on_obstacle) begin
            rgb_nxt = OBST_COLOR;
        end else begin
            rgb_nxt = FLOOR_COLOR;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vga_out <= '0;
        end else begin
            vga_out     <= vga_in;
            vga_out.rgb <= rgb_nxt;
        end
    end

endmodule

`default_nettype wire

/* source/collision.sv */
//#######################################
// Obstacle collision test
// One flag per direction of a single step
//#######################################
`default_nettype none

module collision
    import vga_pkg::*;
    import game_pkg::*;
(
    input  coord_t xpos,
    input  coord_t ypos,
    output logic   col_up,
    output logic   col_down,
    output logic   col_right,
    output logic   col_left
);

    // Square centred at (x, y) spans x-7..x+8 and y-7..y+8
    function automatic logic hits_obstacle(input coord_t x, input coord_t y);
        coord_t left_edge;
        coord_t right_edge;
        coord_t top_edge;
        coord_t bottom_edge;
        left_edge   = x - PLAYER_SIZE + 10'd1;
        right_edge  = x + PLAYER_SIZE;
        top_edge    = y - PLAYER_SIZE + 10'd1;
        bottom_edge = y + PLAYER_SIZE;
        return (left_edge <= OBST_X1) && (right_edge >= OBST_X0)
            && (top_edge <= OBST_Y1) && (bottom_edge >= OBST_Y0);
    endfunction

    coord_t ypos_up;
    coord_t ypos_down;
    coord_t xpos_right;
    coord_t xpos_left;

    // Candidate centres one pixel away
    // The position bounds keep these clear of wrap-around
    assign ypos_up    = ypos - 10'd1;
    assign ypos_down  = ypos + 10'd1;
    assign xpos_right = xpos + 10'd1;
    assign xpos_left  = xpos - 10'd1;

    assign col_up    = hits_obstacle(xpos, ypos_up);
    assign col_down  = hits_obstacle(xpos, ypos_down);
    assign col_right = hits_obstacle(xpos_right, ypos);
    assign col_left  = hits_obstacle(xpos_left, ypos);

endmodule

`default_nettype wire

/* source/draw_player.sv */
//#######################################
// Player stage
// Movement tick, position and clamping
// Cyan square drawn over the stream
//#######################################
`default_nettype none

module draw_player
    import vga_pkg::*;
    import game_pkg::*;
#(
    parameter int STEP_TICKS = 250000
) (
    input  logic     clk,
    input  logic     rst,
    input  buttons_t buttons,
    input  vga_t     vga_in,
    output vga_t     vga_out,
    output coord_t   xpos,
    output coord_t   ypos
);

    localparam int TICK_W = (STEP_TICKS > 1) ? $clog2(STEP_TICKS) : 1;

    logic [TICK_W-1:0] tick;
    coord_t xpos_nxt;
    coord_t ypos_nxt;
    logic   col_up;
    logic   col_down;
    logic   col_right;
    logic   col_left;
    logic   in_square;
    rgb_t   rgb_nxt;

    collision u_collision (
        .xpos      (xpos),
        .ypos      (ypos),
        .col_up    (col_up),
        .col_down  (col_down),
        .col_right (col_right),
        .col_left  (col_left)
    );

    // Movement tick
    // A step is taken whenever it reads 0
    always_ff @(posedge clk) begin
        if (rst) begin
            tick <= '0;
        end else if (tick == TICK_W'(STEP_TICKS - 1)) begin
            tick <= '0;
        end else begin
            tick <= tick + TICK_W'(1);
        end
    end

    // Highest priority button picks the direction
    // A blocked direction is not replaced by a lower one
    always_comb begin
        xpos_nxt = xpos;
        ypos_nxt = ypos;
        if (tick == '0) begin
            if (buttons.up) begin
                if (!col_up && ypos > Y_MIN) begin
                    ypos_nxt = ypos - 10'd1;
                end
            end else if (buttons.down) begin
                if (!col_down && ypos < Y_MAX) begin
                    ypos_nxt = ypos + 10'd1;
                end
            end else if (buttons.right) begin
                if (!col_right && xpos < X_MAX) begin
                    xpos_nxt = xpos + 10'd1;
                end
            end else if (buttons.left) begin
                if (!col_left && xpos > X_MIN) begin
                    xpos_nxt = xpos - 10'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            xpos <= START_X;
            ypos <= START_Y;
        end else begin
            xpos <= xpos_nxt;
            ypos <= ypos_nxt;
        end
    end

    // Same square footprint as the collision test
    assign in_square = (vga_in.hcount >= xpos - PLAYER_SIZE + 10'd1)
                    && (vga_in.hcount <= xpos + PLAYER_SIZE)
                    && (vga_in.vcount >= ypos - PLAYER_SIZE + 10'd1)
                    && (vga_in.vcount <= ypos + PLAYER_SIZE);

    assign rgb_nxt = (in_square && !vga_in.hblnk && !vga_in.vblnk) ? CYAN : vga_in.rgb;

    always_ff @(posedge clk) begin
        if (rst) begin
            vga_out <= '0;
        end else begin
            vga_out     <= vga_in;
            vga_out.rgb <= rgb_nxt;
        end
    end

endmodule

`default_nettype wire

/* source/game_top.sv */
//#######################################
// Game core top level
// Timing, background and player stages
//#######################################
`default_nettype none

module game_top
    import vga_pkg::*;
    import game_pkg::*;
#(
    parameter int STEP_TICKS = 250000
) (
    input  logic      clk,
    input  logic      rst,
    input  buttons_t  buttons,
    output vga_port_t vga,
    output coord_t    xpos,
    output coord_t    ypos
);

    vga_t timing_vga;
    vga_t bg_vga;
    vga_t player_vga;

    vga_timing u_vga_timing (
        .clk (clk),
        .rst (rst),
        .vga (timing_vga)
    );

    draw_background u_draw_background (
        .clk     (clk),
        .rst     (rst),
        .vga_in  (timing_vga),
        .vga_out (bg_vga)
    );

    draw_player #(
        .STEP_TICKS (STEP_TICKS)
    ) u_draw_player (
        .clk     (clk),
        .rst     (rst),
        .buttons (buttons),
        .vga_in  (bg_vga),
        .vga_out (player_vga),
        .xpos    (xpos),
        .ypos    (ypos)
    );

    // Two register stages after the timing generator
    assign vga.hsync = player_vga.hsync;
    assign vga.vsync = player_vga.vsync;
    assign vga.rgb   = player_vga.rgb;

endmodule

`default_nettype wire

/* tests/game_top_asserts.sv */
//#######################################
// Bound checks on the player stage
// Sync inside blanking, position range
// and single pixel steps
//#######################################
`default_nettype none

module game_top_asserts
    import vga_pkg::*;
    import game_pkg::*;
(
    input logic   clk,
    input logic   rst,
    input vga_t   vga,
    input coord_t xpos,
    input coord_t ypos
);

    // Horizontal sync pulse lies inside horizontal blanking
    hsync_in_blank: assert property (@(posedge clk) disable iff (rst)
        !vga.hsync || vga.hblnk)
        else $error("hsync high outside horizontal blanking");

    // Player centre never leaves the area inside the frame
    position_in_bounds: assert property (@(posedge clk) disable iff (rst)
        (xpos >= X_MIN) && (xpos <= X_MAX) && (ypos >= Y_MIN) && (ypos <= Y_MAX))
        else $error("player position outside the border bounds");

    // At most one axis moves and only by one pixel
    single_step: assert property (@(posedge clk) disable iff (rst)
        ((xpos == $past(xpos)) && ((ypos == $past(ypos))
            || (ypos == $past(ypos) + 10'd1) || (ypos + 10'd1 == $past(ypos))))
        || ((ypos == $past(ypos))
            && ((xpos == $past(xpos) + 10'd1) || (xpos + 10'd1 == $past(xpos)))))
        else $error("player moved more than one pixel in a clock");

endmodule

`default_nettype wire

/* tests/game_top_tb.sv */
//#######################################
// Testbench for the game core
// Clock, reset and scenario table
// Position, pixel checks and watchdog
//#######################################
`default_nettype none

module game_top_tb
    import vga_pkg::*;
    import game_pkg::*;
();

    localparam int CLK_PERIOD   = 100;
    localparam int STEP_TICKS   = 16;
    localparam int NUM_ROWS     = 7;
    localparam int LINE_PIXELS  = 800;
    localparam int FRAME_LINES  = 525;
    localparam int FRAME_CYCLES = LINE_PIXELS * FRAME_LINES;
    localparam int VISIBLE_W    = 640;
    localparam int VISIBLE_H    = 480;
    localparam int H_SYNC_FIRST = 656;
    localparam int H_SYNC_LAST  = 751;
    localparam int V_SYNC_FIRST = 490;
    localparam int V_SYNC_LAST  = 491;

    typedef struct packed {
        buttons_t    buttons;
        logic [15:0] steps;
        coord_t      x;
        coord_t      y;
    } scenario_t;

    logic      clk;
    logic      rst;
    buttons_t  buttons;
    vga_port_t vga;
    coord_t    xpos;
    coord_t    ypos;
    scenario_t scenarios [NUM_ROWS];
    string     names [NUM_ROWS];
    logic      table_ready;
    int        cycles_since_reset;

    game_top #(
        .STEP_TICKS (STEP_TICKS)
    ) i_dut (
        .clk     (clk),
        .rst     (rst),
        .buttons (buttons),
        .vga     (vga),
        .xpos    (xpos),
        .ypos    (ypos)
    );

    bind draw_player game_top_asserts i_asserts (
        .clk  (clk),
        .rst  (rst),
        .vga  (vga_out),
        .xpos (xpos),
        .ypos (ypos)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // Clocks since reset release, used to predict the pixel position
    always @(posedge clk) begin
        if (rst) begin
            cycles_since_reset <= 0;
        end else begin
            cycles_since_reset <= cycles_since_reset + 1;
        end
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string test, input int expected, input int actual);
        assert (actual == expected) else begin
            stop_on_error($sformatf("MISMATCH %s: expected %0d actual %0d",
                                    test, expected, actual));
        end
    endtask

    task automatic set_row(input int i, input string name, input logic [3:0] btn,
                           input int steps, input int x, input int y);
        names[i]             = name;
        scenarios[i].buttons = btn;
        scenarios[i].steps   = 16'(steps);
        scenarios[i].x       = 10'(x);
        scenarios[i].y       = 10'(y);
    endtask

    // Compare one output pixel with the timing rules and the sampled colours
    task automatic check_pixel(input string test, input int cx, input int cy);
        int   idx;
        int   h;
        int   v;
        logic exp_hsync;
        logic exp_vsync;
        logic known;
        rgb_t exp_rgb;
        // Two register stages behind the timing counters
        idx = cycles_since_reset - 2;
        h = idx % LINE_PIXELS;
        v = (idx / LINE_PIXELS) % FRAME_LINES;
        exp_hsync = (h >= H_SYNC_FIRST) && (h <= H_SYNC_LAST);
        exp_vsync = (v >= V_SYNC_FIRST) && (v <= V_SYNC_LAST);
        known = 1'b1;
        exp_rgb = BLACK;
        if (h >= VISIBLE_W || v >= VISIBLE_H) begin
            exp_rgb = BLACK;
        end else if (h == cx && v == cy) begin
            exp_rgb = CYAN;
        end else if (h == 2 && v == 200) begin
            exp_rgb = BORDER_COLOR;
        end else if (h == 120 && v == 60) begin
            exp_rgb = OBST_COLOR;
        end else if (h == 300 && v == 300) begin
            exp_rgb = FLOOR_COLOR;
        end else begin
            known = 1'b0;
        end
        assert (vga.hsync == exp_hsync) else begin
            stop_on_error($sformatf("MISMATCH %s hsync at (%0d,%0d): expected %0d actual %0d",
                                    test, h, v, exp_hsync, vga.hsync));
        end
        assert (vga.vsync == exp_vsync) else begin
            stop_on_error($sformatf("MISMATCH %s vsync at (%0d,%0d): expected %0d actual %0d",
                                    test, h, v, exp_vsync, vga.vsync));
        end
        assert (!known || vga.rgb == exp_rgb) else begin
            stop_on_error($sformatf("MISMATCH %s rgb at (%0d,%0d): expected %h actual %h",
                                    test, h, v, exp_rgb, vga.rgb));
        end
    endtask

    // One row lasts steps x STEP_TICKS clocks, so rows stay on the tick grid
    task automatic run_row(input int row);
        scenario_t s;
        logic      idle;
        s = scenarios[row];
        idle = (s.buttons == '0);
        buttons = s.buttons;
        repeat (int'(s.steps) * STEP_TICKS) begin
            @(posedge clk);
            #10;
            if (idle) begin
                check_pixel(names[row], int'(s.x), int'(s.y));
            end
        end
        check_value($sformatf("%s x", names[row]), int'(s.x), int'(xpos));
        check_value($sformatf("%s y", names[row]), int'(s.y), int'(ypos));
    endtask

    initial begin
        int total;
        wait (table_ready);
        total = 4 + 2 * FRAME_CYCLES;
        for (int i = 0; i < NUM_ROWS; i++) begin
            total += int'(scenarios[i].steps) * STEP_TICKS;
        end
        repeat (total) @(posedge clk);
        stop_on_error("timeout, the scenario table did not finish in time");
    end

    initial begin
        rst = 1'b1;
        buttons = '0;
        table_ready = 1'b0;
        // Buttons are up, down, right, left
        set_row(0, "right_free", 4'b0010, 20, 52, 32);
        set_row(1, "up_over_left", 4'b1001, 1, 52, 31);
        set_row(2, "up_clamp", 4'b1000, 30, 52, 16);
        set_row(3, "left_clamp", 4'b0001, 40, 16, 16);
        set_row(4, "down_to_48", 4'b0100, 32, 16, 48);
        // Square right edge x+8 must stay below the obstacle at 100
        set_row(5, "right_blocked", 4'b0010, 80, 100 - 8 - 1, 48);
        set_row(6, "idle_frame", 4'b0000, FRAME_CYCLES / STEP_TICKS, 91, 48);
        table_ready = 1'b1;

        repeat (2) @(posedge clk);
        #10;
        check_value("reset hsync", 0, int'(vga.hsync));
        check_value("reset vsync", 0, int'(vga.vsync));
        check_value("reset rgb", 0, int'(vga.rgb));
        check_value("reset xpos", 32, int'(xpos));
        check_value("reset ypos", 32, int'(ypos));
        repeat (2) @(posedge clk);
        #10;
        rst = 1'b0;

        for (int row = 0; row < NUM_ROWS; row++) begin
            run_row(row);
        end

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
source/vga_pkg.sv
source/game_pkg.sv
source/vga_timing.sv
source/draw_background.sv
source/collision.sv
source/draw_player.sv
source/game_top.sv
tests/game_top_asserts.sv
tests/game_top_tb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator and run it, the exit status gives the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f vlog.f --top-module game_top_tb -o game_top_tb_sim &&
./obj_dir/game_top_tb_sim || exit 1
